// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f tartaruga_dmem.f \
		--top-module dmem_subsys_tb -Mdir obj_dir -o dmem_subsys_tb

run: compile
	./obj_dir/dmem_subsys_tb | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/dmem_subsys_tb.sv ====
`default_nettype none

`include "tartaruga_params.svh"

module dmem_subsys_tb
    import tartaruga_pkg::*;
    import lsu_pkg::*;
();

    typedef struct packed {
        bus32_t    addr;
        logic      we;
        mem_size_t size;
        logic      uns;
        bus32_t    wdata;
    } req_item_t;

    logic      clk_i;
    logic      rstn_i;
    logic      req_valid_i;
    logic      req_ready_o;
    bus32_t    req_addr_i;
    logic      req_we_i;
    mem_size_t req_size_i;
    logic      req_unsigned_i;
    bus32_t    req_wdata_i;
    logic      rsp_valid_o;
    logic      rsp_ready_i;
    bus32_t    rsp_rdata_o;

    // Byte model of the 4 KiB the address wraps over
    logic [7:0] model_mem [4096];
    req_item_t  req_q [$];
    bus32_t     exp_q [$];
    int         acc_cyc_q [$];
    string      test_name;
    int         cyc;
    int         stall_pct;
    int         hold_cycles;
    logic       check_lat;
    logic       saw_full;

    dmem_subsys_top UUT (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_addr_i     (req_addr_i),
        .req_we_i       (req_we_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_wdata_i    (req_wdata_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_rdata_o    (rsp_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input bus32_t exp, input bus32_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %08h, actual %08h", what, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_cycles(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s: expected %0d, actual %0d", what, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic bus32_t predict_load(input req_item_t it);
        logic [11:0] a;
        bus32_t      w;
        a = it.addr[11:0];
        w = {model_mem[a + 12'd3], model_mem[a + 12'd2], model_mem[a + 12'd1], model_mem[a]};
        case (it.size)
            MEM_BYTE: predict_load = it.uns ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            MEM_HALF: predict_load = it.uns ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            default:  predict_load = w;
        endcase
    endfunction

    task automatic apply_store(input req_item_t it);
        int n;
        n = (it.size == MEM_BYTE) ? 1 : (it.size == MEM_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model_mem[it.addr[11:0] + 12'(i)] = it.wdata[i*8 +: 8];
        end
    endtask

    // Model sees every access in accept order, like the memory does
    task automatic accept_req(input req_item_t it);
        if (it.we) begin
            apply_store(it);
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(predict_load(it));
        end
        acc_cyc_q.push_back(cyc);
    endtask

    task automatic queue_req(input bus32_t addr, input logic we, input mem_size_t size,
                             input logic uns, input bus32_t wdata);
        req_item_t it;
        it.addr  = addr;
        it.we    = we;
        it.size  = size;
        it.uns   = uns;
        it.wdata = wdata;
        req_q.push_back(it);
    endtask

    task automatic drive_inputs();
        req_item_t it;
        if (req_q.size() != 0) begin
            it             = req_q[0];
            req_valid_i    = 1'b1;
            req_addr_i     = it.addr;
            req_we_i       = it.we;
            req_size_i     = it.size;
            req_unsigned_i = it.uns;
            req_wdata_i    = it.wdata;
        end else begin
            req_valid_i = 1'b0;
        end
        if (hold_cycles > 0) begin
            rsp_ready_i = 1'b0;
            hold_cycles--;
        end else begin
            rsp_ready_i = int'($urandom % 100) >= stall_pct;
        end
    endtask

    // One iteration per clock; inputs change on the falling edge, outputs sampled after
    task automatic run_traffic(input int max_cycles);
        bus32_t held;
        logic   held_valid;
        int     n;
        int     acc;
        held       = '0;
        held_valid = 1'b0;
        n          = 0;
        while (req_q.size() != 0 || exp_q.size() != 0) begin
            if (n == max_cycles) begin
                stop_with_error({test_name, " timed out waiting for responses"});
            end
            n++;
            drive_inputs();
            #1;
            if (held_valid && !rsp_valid_o) begin
                stop_with_error({test_name, " dropped a held response"});
            end
            if (held_valid) begin
                check_word({test_name, " held response"}, held, rsp_rdata_o);
            end
            held_valid = rsp_valid_o && !rsp_ready_i;
            held       = rsp_rdata_o;
            if (!req_ready_o) begin
                saw_full = 1'b1;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    stop_with_error({test_name, " got a response with nothing outstanding"});
                end
                check_word(test_name, exp_q.pop_front(), rsp_rdata_o);
                acc = acc_cyc_q.pop_front();
                if (check_lat) begin
                    check_cycles({test_name, " latency"}, `DMEM_LAT, cyc - acc);
                end
            end
            if (req_valid_i && req_ready_o) begin
                accept_req(req_q.pop_front());
            end
            cyc++;
            @(negedge clk_i);
        end
    endtask

    task automatic test_word_round_trip();
        test_name = "word_round_trip";
        for (int i = 0; i < 8; i++) begin
            queue_req(bus32_t'(i) * 32'h214, 1'b1, MEM_WORD, 1'b0,
                      32'hc0de_0000 + bus32_t'(i) * 32'h0101_0101);
        end
        for (int i = 0; i < 8; i++) begin
            queue_req(bus32_t'(i) * 32'h214, 1'b0, MEM_WORD, 1'b0, '0);
        end
        run_traffic(200);
    endtask

    task automatic test_narrow_access();
        test_name = "narrow_access";
        queue_req(32'h40, 1'b1, MEM_WORD, 1'b0, 32'h1122_3344);
        queue_req(32'h41, 1'b1, MEM_BYTE, 1'b0, 32'hdead_bea5);
        queue_req(32'h42, 1'b1, MEM_HALF, 1'b0, 32'h7777_8001);
        queue_req(32'h40, 1'b0, MEM_WORD, 1'b0, '0);
        queue_req(32'h41, 1'b0, MEM_BYTE, 1'b0, '0);
        queue_req(32'h41, 1'b0, MEM_BYTE, 1'b1, '0);
        queue_req(32'h40, 1'b0, MEM_BYTE, 1'b0, '0);
        queue_req(32'h40, 1'b0, MEM_HALF, 1'b0, '0);
        queue_req(32'h42, 1'b0, MEM_HALF, 1'b0, '0);
        queue_req(32'h42, 1'b0, MEM_HALF, 1'b1, '0);
        run_traffic(200);
    endtask

    task automatic test_pipelining();
        int first_cyc;
        test_name = "pipelining";
        check_lat = 1'b1;
        first_cyc = cyc;
        for (int i = 0; i < `DMEM_LAT; i++) begin
            queue_req(bus32_t'(i) * 32'h214, 1'b0, MEM_WORD, 1'b0, '0);
        end
        run_traffic(100);
        // Back-to-back accepts followed by the last response
        check_cycles({test_name, " total cycles"}, 2 * `DMEM_LAT, cyc - first_cyc);
        check_lat = 1'b0;
    endtask

    task automatic test_back_pressure();
        test_name   = "back_pressure";
        saw_full    = 1'b0;
        hold_cycles = 4 * `DMEM_LAT;
        for (int i = 0; i < `DMEM_LAT; i++) begin
            queue_req(32'h300 + bus32_t'(i) * 4, 1'b1, MEM_WORD, 1'b0, 32'hbeef_0000 + bus32_t'(i));
            queue_req(32'h300 + bus32_t'(i) * 4, 1'b0, MEM_WORD, 1'b0, '0);
        end
        run_traffic(300);
        if (!saw_full) begin
            stop_with_error("request ready never fell while responses were held");
        end
    endtask

    task automatic test_address_wrap();
        test_name = "address_wrap";
        queue_req(32'h7ab0_0124, 1'b1, MEM_WORD, 1'b0, 32'h5a5a_0f0f);
        queue_req(32'h0000_0124, 1'b0, MEM_WORD, 1'b0, '0);
        queue_req(32'hffff_f124, 1'b0, MEM_WORD, 1'b0, '0);
        run_traffic(100);
    endtask

    task automatic test_random_traffic();
        bus32_t    a;
        mem_size_t sz;
        int        r;
        test_name = "random_traffic";
        // Lines 0 to 7 get known contents first
        for (int i = 0; i < 32; i++) begin
            queue_req(bus32_t'(i) * 4, 1'b1, MEM_WORD, 1'b0, $urandom);
        end
        run_traffic(300);
        for (int i = 0; i < 200; i++) begin
            r  = int'($urandom % 3);
            sz = (r == 0) ? MEM_BYTE : (r == 1) ? MEM_HALF : MEM_WORD;
            a  = $urandom & 32'hffff_f07f;
            if (sz == MEM_HALF) begin
                a[0] = 1'b0;
            end
            if (sz == MEM_WORD) begin
                a[1:0] = 2'b00;
            end
            queue_req(a, $urandom % 2 == 1, sz, $urandom % 2 == 1, $urandom);
        end
        stall_pct = 30;
        run_traffic(5000);
        stall_pct = 0;
    endtask

    initial begin
        int n;
        void'($urandom(32'h8a34_9ae2));
        rstn_i         = 1'b0;
        req_valid_i    = 1'b0;
        req_addr_i     = '0;
        req_we_i       = 1'b0;
        req_size_i     = MEM_WORD;
        req_unsigned_i = 1'b0;
        req_wdata_i    = '0;
        rsp_ready_i    = 1'b0;
        stall_pct      = 0;
        hold_cycles    = 0;
        check_lat      = 1'b0;
        saw_full       = 1'b0;
        cyc            = 0;
        test_name      = "reset";
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        n = 0;
        while (!req_ready_o) begin
            if (n == 20) begin
                stop_with_error("request ready did not rise after reset");
            end
            n++;
            @(negedge clk_i);
        end
        if (rsp_valid_o) begin
            stop_with_error("response valid was high right after reset");
        end
        test_word_round_trip();
        test_narrow_access();
        test_pipelining();
        test_back_pressure();
        test_address_wrap();
        test_random_traffic();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/dmem_line_store.sv ====
`default_nettype none

`include "tartaruga_params.svh"

module dmem_line_store
    import tartaruga_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rstn_i,
    input  wire logic   req_valid_i,
    output logic        req_ready_o,
    input  wire bus32_t addr_i,
    input  wire logic   we_i,
    input  wire logic [`LINE_BITS/8-1:0] be_i,
    input  wire line_t  wdata_i,
    output logic        rsp_valid_o,
    input  wire logic   rsp_ready_i,
    output bus32_t      rsp_addr_o,
    output line_t       rsp_line_o
);

    localparam int unsigned LAT   = `DMEM_LAT;
    localparam int unsigned BYTES = `LINE_BITS / 8;

    line_t mem_q [`DMEM_LINES];

    dmem_addr_u req_addr;
    logic       req_accept;
    logic [`LINE_BITS-1:0] old_bits;
    logic [`LINE_BITS-1:0] new_bits;
    logic [`LINE_BITS-1:0] wdata_bits;
    bus32_t     line_base;

    logic [LAT-1:0] stage_valid_q;
    logic [LAT-1:0] stage_ready;
    line_t          stage_line_q [LAT];
    bus32_t         stage_addr_q [LAT];

    assign req_addr.raw = addr_i;
    assign wdata_bits   = wdata_i;
    assign line_base    = {req_addr.f.upper, req_addr.f.line_idx, 4'b0000};

    // A stage can take new data if it is empty or its content moves on
    always_comb begin
        stage_ready[LAT-1] = !stage_valid_q[LAT-1] || rsp_ready_i;
        for (int i = LAT - 2; i >= 0; i--) begin
            stage_ready[i] = !stage_valid_q[i] || stage_ready[i+1];
        end
    end

    assign req_ready_o = stage_ready[0];
    assign req_accept  = req_valid_i && req_ready_o;

    // Byte-masked merge of the store into the current line
    always_comb begin
        old_bits = mem_q[req_addr.f.line_idx];
        new_bits = old_bits;
        for (int b = 0; b < BYTES; b++) begin
            if (we_i && be_i[b]) begin
                new_bits[b*8 +: 8] = wdata_bits[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept && we_i) begin
            mem_q[req_addr.f.line_idx] <= new_bits;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stage_valid_q <= '0;
        end else begin
            if (stage_ready[0]) begin
                stage_valid_q[0] <= req_accept;
            end
            for (int i = 1; i < LAT; i++) begin
                if (stage_ready[i]) begin
                    stage_valid_q[i] <= stage_valid_q[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            stage_line_q[0] <= new_bits;
            stage_addr_q[0] <= line_base;
        end
        for (int i = 1; i < LAT; i++) begin
            if (stage_ready[i] && stage_valid_q[i-1]) begin
                stage_line_q[i] <= stage_line_q[i-1];
                stage_addr_q[i] <= stage_addr_q[i-1];
            end
        end
    end

    assign rsp_valid_o = stage_valid_q[LAT-1];
    assign rsp_line_o  = stage_line_q[LAT-1];
    assign rsp_addr_o  = stage_addr_q[LAT-1];

    // Stalled response must hold until taken
    a_rsp_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=>
            rsp_valid_o && $stable(rsp_line_o) && $stable(rsp_addr_o)
    );

endmodule

`default_nettype wire

// ==== hdl/dmem_subsys_top.sv ====
`default_nettype none

module dmem_subsys_top
    import tartaruga_pkg::*;
    import lsu_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rstn_i,
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    input  wire bus32_t    req_addr_i,
    input  wire logic      req_we_i,
    input  wire mem_size_t req_size_i,
    input  wire logic      req_unsigned_i,
    input  wire bus32_t    req_wdata_i,
    output logic           rsp_valid_o,
    input  wire logic      rsp_ready_i,
    output bus32_t         rsp_rdata_o
);

    logic         queue_ready;
    logic         mem_req_valid;
    logic         mem_req_ready;
    bus32_t       mem_addr;
    logic         mem_we;
    logic [15:0]  mem_be;
    line_t        mem_wdata;
    logic         pend_push;
    lsu_pending_t pend;
    logic         line_valid;
    logic         line_ready;
    line_t        line;

    lsu_store_align u_align (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_addr_i      (req_addr_i),
        .req_we_i        (req_we_i),
        .req_size_i      (req_size_i),
        .req_unsigned_i  (req_unsigned_i),
        .req_wdata_i     (req_wdata_i),
        .queue_ready_i   (queue_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_addr_o      (mem_addr),
        .mem_we_o        (mem_we),
        .mem_be_o        (mem_be),
        .mem_wdata_o     (mem_wdata),
        .pend_push_o     (pend_push),
        .pend_o          (pend)
    );

    // Line address is not needed on the response side
    dmem_line_store u_mem (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .addr_i      (mem_addr),
        .we_i        (mem_we),
        .be_i        (mem_be),
        .wdata_i     (mem_wdata),
        .rsp_valid_o (line_valid),
        .rsp_ready_i (line_ready),
        .rsp_addr_o  (),
        .rsp_line_o  (line)
    );

    lsu_load_extract u_extract (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .pend_push_i   (pend_push),
        .pend_i        (pend),
        .queue_ready_o (queue_ready),
        .line_valid_i  (line_valid),
        .line_ready_o  (line_ready),
        .line_i        (line),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_rdata_o   (rsp_rdata_o)
    );

endmodule

`default_nettype wire

// ==== hdl/lsu_load_extract.sv ====
`default_nettype none

`include "tartaruga_params.svh"

module lsu_load_extract
    import tartaruga_pkg::*;
    import lsu_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rstn_i,
    input  wire logic         pend_push_i,
    input  wire lsu_pending_t pend_i,
    output logic              queue_ready_o,
    input  wire logic         line_valid_i,
    output logic              line_ready_o,
    input  wire line_t        line_i,
    output logic              rsp_valid_o,
    input  wire logic         rsp_ready_i,
    output bus32_t            rsp_rdata_o
);

    localparam int unsigned DEPTH = `DMEM_LAT;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    lsu_pending_t     queue_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;
    logic             full;

    lsu_pending_t head;
    bus32_t       sel_word;
    bus32_t       lane;
    bus32_t       ext_data;

    assign full = (count_q == CNT_W'(DEPTH));
    assign pop  = rsp_valid_o && rsp_ready_i;

    // A slot frees up in the same cycle the head is taken
    assign queue_ready_o = !full || pop;

    assign rsp_valid_o  = line_valid_i;
    assign line_ready_o = rsp_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (pend_push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (pend_push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !pend_push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pend_push_i) begin
            queue_q[wr_ptr_q] <= pend_i;
        end
    end

    assign head     = queue_q[rd_ptr_q];
    assign sel_word = line_i[head.word_sel];
    assign lane     = sel_word >> {head.byte_sel, 3'b000};

    always_comb begin
        unique case (head.size)
            MEM_BYTE: begin
                ext_data = head.is_unsigned ? {24'b0, lane[7:0]}
                                            : {{24{lane[7]}}, lane[7:0]};
            end
            MEM_HALF: begin
                ext_data = head.is_unsigned ? {16'b0, lane[15:0]}
                                            : {{16{lane[15]}}, lane[15:0]};
            end
            default: ext_data = lane;
        endcase
    end

    // Stores answer with zero
    assign rsp_rdata_o = head.store ? '0 : ext_data;

    a_line_has_pending: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        line_valid_i |-> count_q != '0
    );

    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pend_push_i |-> !full || pop
    );

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    // What the response path needs to know about an issued access
    typedef struct packed {
        logic      store;
        mem_size_t size;
        logic      is_unsigned;
        logic [1:0] word_sel;
        logic [1:0] byte_sel;
    } lsu_pending_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_store_align.sv ====
`default_nettype none

module lsu_store_align
    import tartaruga_pkg::*;
    import lsu_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rstn_i,
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    input  wire bus32_t    req_addr_i,
    input  wire logic      req_we_i,
    input  wire mem_size_t req_size_i,
    input  wire logic      req_unsigned_i,
    input  wire bus32_t    req_wdata_i,
    input  wire logic      queue_ready_i,
    output logic           mem_req_valid_o,
    input  wire logic      mem_req_ready_i,
    output bus32_t         mem_addr_o,
    output logic           mem_we_o,
    output logic [15:0]    mem_be_o,
    output line_t          mem_wdata_o,
    output logic           pend_push_o,
    output lsu_pending_t   pend_o
);

    dmem_addr_u addr;
    logic [3:0] word_be;
    bus32_t     lane_data;
    logic       aligned;

    assign addr.raw = req_addr_i;

    always_comb begin
        unique case (req_size_i)
            MEM_BYTE: begin
                word_be   = 4'b0001 << addr.f.byte_sel;
                lane_data = {4{req_wdata_i[7:0]}};
            end
            MEM_HALF: begin
                word_be   = 4'b0011 << addr.f.byte_sel;
                lane_data = {2{req_wdata_i[15:0]}};
            end
            default: begin
                word_be   = 4'b1111;
                lane_data = req_wdata_i;
            end
        endcase
    end

    // Loads carry no byte enables
    assign mem_be_o    = req_we_i ? ({12'b0, word_be} << {addr.f.word_sel, 2'b00}) : '0;
    assign mem_wdata_o = {4{lane_data}};
    assign mem_addr_o  = req_addr_i;
    assign mem_we_o    = req_we_i;

    // Only forward when the response queue has room
    assign mem_req_valid_o = req_valid_i && queue_ready_i;
    assign req_ready_o     = mem_req_ready_i && queue_ready_i;
    assign pend_push_o     = req_valid_i && req_ready_o;

    assign pend_o.store       = req_we_i;
    assign pend_o.size        = req_size_i;
    assign pend_o.is_unsigned = req_unsigned_i;
    assign pend_o.word_sel    = addr.f.word_sel;
    assign pend_o.byte_sel    = addr.f.byte_sel;

    assign aligned = (req_size_i == MEM_BYTE) ||
                     (req_size_i == MEM_HALF && !addr.f.byte_sel[0]) ||
                     (req_size_i == MEM_WORD && addr.f.byte_sel == 2'b00);

    a_aligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |-> aligned
    );

    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        req_valid_i && !req_ready_o |=>
            req_valid_i && $stable({req_addr_i, req_we_i, req_size_i,
                                    req_unsigned_i, req_wdata_i})
    );

endmodule

`default_nettype wire

// ==== hdl/tartaruga_params.svh ====
`ifndef TARTARUGA_PARAMS_SVH
`define TARTARUGA_PARAMS_SVH

// Pipeline stages in the data line memory
`define DMEM_LAT 5

// Number of lines held by the data memory
`define DMEM_LINES 256

// Width of one memory line in bits
`define LINE_BITS 128

`endif

// ==== hdl/tartaruga_pkg.sv ====
`default_nettype none

`include "tartaruga_params.svh"

package tartaruga_pkg;

    localparam int unsigned LINE_WORDS = `LINE_BITS / 32;
    localparam int unsigned LINE_IDX_W = $clog2(`DMEM_LINES);

    typedef logic [31:0] bus32_t;

    typedef bus32_t [LINE_WORDS-1:0] line_t;

    // Bits above the line index are ignored, so addresses wrap
    typedef struct packed {
        logic [31-LINE_IDX_W-4:0] upper;
        logic [LINE_IDX_W-1:0]    line_idx;
        logic [1:0]               word_sel;
        logic [1:0]               byte_sel;
    } dmem_addr_fields_t;

    typedef union packed {
        bus32_t            raw;
        dmem_addr_fields_t f;
    } dmem_addr_u;

endpackage

`default_nettype wire

// ==== tartaruga_dmem.f ====
+incdir+hdl
hdl/tartaruga_pkg.sv
hdl/lsu_pkg.sv
hdl/dmem_line_store.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extract.sv
hdl/dmem_subsys_top.sv
dv/dmem_subsys_tb.sv
